/* dv/execGolden.txt */
# word opA opB kind dest value, all hex except dest in decimal
# kind: R result, O overflow trap, X reserved instruction, N no pulse
00221820 00000005 00000007 R 3 0000000c
00222021 ffffffff 00000002 R 4 00000001
00222822 0000000a 00000003 R 5 00000007
00223023 00000003 0000000a R 6 fffffff9
00223824 f0f0f0f0 ff00ff00 R 7 f000f000
00224025 f0f0f0f0 0f0f0000 R 8 fffff0f0
00224826 aaaa5555 ffff0000 R 9 55555555
00225027 0000ffff 00ff0000 R 10 ff000000
0022182a ffffffff 00000001 R 3 00000001
0022202b ffffffff 00000001 R 4 00000000
00222900 00000000 8000000f R 5 000000f0
00223202 00000000 80000000 R 6 00800000
00223a03 00000000 80000000 R 7 ff800000
2023fffe 00000005 00000000 R 3 00000003
2825ffff fffffffe 00000000 R 5 00000001
3026ffff 12345678 00000000 R 6 00005678
34278000 00000001 00000000 R 7 00008001
3c091234 00000000 00000000 R 9 12340000
00220020 00000001 00000001 R 0 00000002
00221820 7fffffff 00000001 O 0 00000000
00221821 7fffffff 00000001 R 3 80000000
00222022 80000000 00000001 O 0 00000000
00222023 80000000 00000001 R 4 7fffffff
20250001 7fffffff 00000000 O 0 00000000
24250001 7fffffff 00000000 R 5 80000000
00220018 fffffffe 00000003 N 0 00000000
00001810 00000000 00000000 R 3 ffffffff
00002012 00000000 00000000 R 4 fffffffa
00220019 ffffffff 00000002 N 0 00000000
00002812 00000000 00000000 R 5 fffffffe
00003010 00000000 00000000 R 6 00000001
0022001a fffffff9 00000002 N 0 00000000
00003812 00000000 00000000 R 7 fffffffd
00004010 00000000 00000000 R 8 ffffffff
0022001b 00000007 00000002 N 0 00000000
00224820 00000010 00000020 R 9 00000030
00005010 00000000 00000000 R 10 00000001
00001812 00000000 00000000 R 3 00000003
0022001b 00000005 00000000 N 0 00000000
00002010 00000000 00000000 R 4 00000001
00002812 00000000 00000000 R 5 00000003
00200011 13572468 00000000 N 0 00000000
00200013 24681357 00000000 N 0 00000000
00003010 00000000 00000000 R 6 13572468
00003812 00000000 00000000 R 7 24681357
8c220000 00000000 00000000 X 0 00000000
00200008 00000000 00000000 X 0 00000000

/* tb.f */
source/execPkg.sv
source/aluUnit.sv
source/mulDivUnit.sv
source/resultMerge.sv
source/execStage.sv
dv/execStageTb.sv

/* run.sh */
#!/bin/sh
# Build and run the execute-stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module execStageTb -f tb.f -o execSim
./obj_dir/execSim > sim.log 2>&1 || true
cat sim.log

if grep -qx "TESTS PASSED" sim.log; then
    echo "Simulation passed, log in sim.log"
else
    echo "Simulation failed, log in sim.log"
    exit 1
fi

/* dv/execStageTb.sv */
`timescale 1ns/10ps

module execStageTb;

    localparam int StallLimit = 24;
    localparam int DrainCycles = 3;

    logic clk;
    logic reset;
    logic issue;
    execPkg::instr_t instr;
    execPkg::word_t opA;
    execPkg::word_t opB;
    logic resultValid;
    execPkg::word_t result;
    execPkg::regIdx_t destReg;
    logic overflow;
    logic reservedInstr;
    logic stall;

    // Golden lines, loaded before the run
    execPkg::instr_t wordQ[$];
    execPkg::word_t opAQ[$];
    execPkg::word_t opBQ[$];
    string kindQ[$];
    execPkg::regIdx_t destQ[$];
    execPkg::word_t valueQ[$];
    int lineQ[$];

    // What the cycle after acceptance must show
    logic pendValid;
    string pendKind;
    execPkg::regIdx_t pendDest;
    execPkg::word_t pendValue;
    int pendLine;

    // Busy cycles still ahead, and whether the held word uses HI/LO
    int busyLeft;
    logic holdHiLo;

    logic [7:0] lfsrState;

    execStage DUT (
        .clk(clk),
        .reset(reset),
        .issue(issue),
        .instr(instr),
        .opA(opA),
        .opB(opB),
        .resultValid(resultValid),
        .result(result),
        .destReg(destReg),
        .overflow(overflow),
        .reservedInstr(reservedInstr),
        .stall(stall)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic stopRun();
        $display("TESTS FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic reportProblem(input string msg);
        $display("%s", msg);
        stopRun();
    endtask

    task automatic checkWord(input execPkg::word_t got, input execPkg::word_t expected,
                             input string what);
        if (got !== expected) begin
            $display("Fail at %0t: %s is %h, expected %h", $time, what, got, expected);
            stopRun();
        end
    endtask

    task automatic checkReg(input execPkg::regIdx_t got, input execPkg::regIdx_t expected,
                            input string what);
        if (got !== expected) begin
            $display("Fail at %0t: %s is %0d, expected %0d", $time, what, got, expected);
            stopRun();
        end
    endtask

    task automatic checkBit(input logic got, input logic expected, input string what);
        if (got !== expected) begin
            $display("Fail at %0t: %s is %b, expected %b", $time, what, got, expected);
            stopRun();
        end
    endtask

    // x^8 + x^6 + x^5 + x^4 + 1
    function automatic logic [7:0] lfsrNext(input logic [7:0] state);
        logic feedback;
        feedback = state[7] ^ state[5] ^ state[4] ^ state[3];
        return {state[6:0], feedback};
    endfunction

    // Two bits give 0 to 3 idle cycles
    task automatic drawGap(output int gap);
        int b;
        gap = 0;
        for (b = 0; b < 2; b++) begin
            lfsrState = lfsrNext(lfsrState);
            gap = (gap << 1) | int'(lfsrState[0]);
        end
    endtask

    function automatic logic touchesHiLo(input execPkg::instr_t word);
        logic hit;
        hit = 1'b0;
        if (word.rType.opcode == execPkg::OpSpecial) begin
            case (word.rType.funct)
                execPkg::FnMult, execPkg::FnMultu, execPkg::FnDiv, execPkg::FnDivu,
                execPkg::FnMfhi, execPkg::FnMflo, execPkg::FnMthi, execPkg::FnMtlo: hit = 1'b1;
                default: hit = 1'b0;
            endcase
        end
        return hit;
    endfunction

    // Busy cycles started by an accepted word, zero if it starts none
    function automatic int startLatency(input execPkg::instr_t word);
        int cycles;
        cycles = 0;
        if (word.rType.opcode == execPkg::OpSpecial) begin
            case (word.rType.funct)
                execPkg::FnMult, execPkg::FnMultu: cycles = int'(execPkg::MulLatency);
                execPkg::FnDiv, execPkg::FnDivu: cycles = int'(execPkg::DivLatency);
                default: cycles = 0;
            endcase
        end
        return cycles;
    endfunction

    task automatic loadGolden();
        int fd;
        int got;
        int fields;
        int dest;
        int lineNo;
        string text;
        string kind;
        logic [31:0] word;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] value;
        fd = $fopen("dv/execGolden.txt", "r");
        if (fd == 0) begin
            reportProblem("Cannot open dv/execGolden.txt");
        end
        lineNo = 0;
        while (!$feof(fd)) begin
            text = "";
            got = $fgets(text, fd);
            lineNo++;
            if (got == 0 || text.len() < 2 || text[0] == "#") begin
                continue;
            end
            fields = $sscanf(text, "%h %h %h %s %d %h", word, a, b, kind, dest, value);
            if (fields != 6) begin
                reportProblem($sformatf("Malformed golden line %0d", lineNo));
            end
            if (kind != "R" && kind != "O" && kind != "X" && kind != "N") begin
                reportProblem($sformatf("Unknown kind %s on golden line %0d", kind, lineNo));
            end
            wordQ.push_back(execPkg::instr_t'(word));
            opAQ.push_back(a);
            opBQ.push_back(b);
            kindQ.push_back(kind);
            destQ.push_back(execPkg::regIdx_t'(dest));
            valueQ.push_back(value);
            lineQ.push_back(lineNo);
        end
        $fclose(fd);
    endtask

    // Runs at every falling edge
    task automatic checkCycle();
        logic expR;
        logic expO;
        logic expX;
        expR = pendValid && pendKind == "R";
        expO = pendValid && pendKind == "O";
        expX = pendValid && pendKind == "X";
        if ({resultValid, overflow, reservedInstr} !== {expR, expO, expX}) begin
            reportProblem($sformatf(
                "Wrong pulses at %0t after golden line %0d: valid %b overflow %b reserved %b",
                $time, pendLine, resultValid, overflow, reservedInstr));
        end
        if (expR) begin
            checkReg(destReg, pendDest, $sformatf("destReg for golden line %0d", pendLine));
            checkWord(result, pendValue, $sformatf("result for golden line %0d", pendLine));
        end
        checkBit(stall, holdHiLo && busyLeft > 0, "stall");
        if (busyLeft > 0) begin
            busyLeft--;
        end
        pendValid = 1'b0;
    endtask

    initial begin
        int gap;
        int idx;
        int waited;
        int lat;
        reset <= 1'b1;
        issue <= 1'b0;
        instr <= '0;
        opA <= '0;
        opB <= '0;
        pendValid = 1'b0;
        pendLine = 0;
        busyLeft = 0;
        holdHiLo = 1'b0;
        lfsrState = 8'd33;
        loadGolden();

        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        if (resultValid || overflow || reservedInstr || stall) begin
            reportProblem("Outputs are not idle after reset");
        end
        @(posedge clk);

        for (idx = 0; idx < wordQ.size(); idx++) begin
            drawGap(gap);
            repeat (gap) begin
                issue <= 1'b0;
                holdHiLo = 1'b0;
                @(negedge clk);
                checkCycle();
                @(posedge clk);
            end
            issue <= 1'b1;
            instr <= wordQ[idx];
            opA <= opAQ[idx];
            opB <= opBQ[idx];
            holdHiLo = touchesHiLo(wordQ[idx]);

            // Hold the word while stalled
            waited = 0;
            @(negedge clk);
            checkCycle();
            while (stall) begin
                waited++;
                if (waited > StallLimit) begin
                    reportProblem($sformatf("Timeout: stall never cleared for golden line %0d",
                                            lineQ[idx]));
                end
                @(negedge clk);
                checkCycle();
            end

            // Acceptance edge
            @(posedge clk);
            lat = startLatency(wordQ[idx]);
            if (lat > 0) begin
                busyLeft = lat;
            end
            pendValid = 1'b1;
            pendKind = kindQ[idx];
            pendDest = destQ[idx];
            pendValue = valueQ[idx];
            pendLine = lineQ[idx];
        end

        issue <= 1'b0;
        holdHiLo = 1'b0;
        repeat (DrainCycles) begin
            @(negedge clk);
            checkCycle();
        end

        if (wordQ.size() > 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("No instructions were read from dv/execGolden.txt");
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* source/execStage.sv */
`timescale 1ns/10ps

module execStage (
    input logic clk,
    input logic reset,
    input logic issue,
    input execPkg::instr_t instr,
    input execPkg::word_t opA,
    input execPkg::word_t opB,
    output logic resultValid,
    output execPkg::word_t result,
    output execPkg::regIdx_t destReg,
    output logic overflow,
    output logic reservedInstr,
    output logic stall
);

    logic aluHit;
    execPkg::word_t aluResult;
    execPkg::regIdx_t aluDest;
    logic aluOverflow;
    logic mulHit;
    execPkg::word_t mulResult;
    execPkg::regIdx_t mulDest;

    aluUnit alu (
        .issue(issue),
        .stall(stall),
        .instr(instr),
        .opA(opA),
        .opB(opB),
        .aluHit(aluHit),
        .aluResult(aluResult),
        .aluDest(aluDest),
        .aluOverflow(aluOverflow)
    );

    mulDivUnit mulDiv (
        .clk(clk),
        .reset(reset),
        .issue(issue),
        .instr(instr),
        .opA(opA),
        .opB(opB),
        .mulHit(mulHit),
        .mulResult(mulResult),
        .mulDest(mulDest),
        .stall(stall)
    );

    resultMerge merge (
        .clk(clk),
        .reset(reset),
        .issue(issue),
        .stall(stall),
        .aluHit(aluHit),
        .aluResult(aluResult),
        .aluDest(aluDest),
        .aluOverflow(aluOverflow),
        .mulHit(mulHit),
        .mulResult(mulResult),
        .mulDest(mulDest),
        .resultValid(resultValid),
        .result(result),
        .destReg(destReg),
        .overflow(overflow),
        .reservedInstr(reservedInstr)
    );

endmodule

/* source/resultMerge.sv */
`timescale 1ns/10ps

module resultMerge (
    input logic clk,
    input logic reset,
    input logic issue,
    input logic stall,
    input logic aluHit,
    input execPkg::word_t aluResult,
    input execPkg::regIdx_t aluDest,
    input logic aluOverflow,
    input logic mulHit,
    input execPkg::word_t mulResult,
    input execPkg::regIdx_t mulDest,
    output logic resultValid,
    output execPkg::word_t result,
    output execPkg::regIdx_t destReg,
    output logic overflow,
    output logic reservedInstr
);

    logic accepted;
    logic aluWrite;
    logic mulWrite;

    assign accepted = issue && !stall;
    assign aluWrite = aluHit && !aluOverflow;

    // Only mfhi/mflo carry a nonzero destination out of the mul/div side
    assign mulWrite = mulHit && (mulDest != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            resultValid <= 1'b0;
            overflow <= 1'b0;
            reservedInstr <= 1'b0;
        end else begin
            resultValid <= aluWrite || mulWrite;
            overflow <= aluHit && aluOverflow;
            reservedInstr <= accepted && !aluHit && !mulHit;
        end
    end

    always_ff @(posedge clk) begin
        if (aluHit) begin
            result <= aluResult;
            destReg <= aluDest;
        end else begin
            result <= mulResult;
            destReg <= mulDest;
        end
    end

    unitsExclusive: assert property (@(posedge clk) disable iff (reset) !(aluHit && mulHit));

    onePulseAtMost: assert property (
        @(posedge clk) disable iff (reset) $onehot0({resultValid, overflow, reservedInstr}));

endmodule

/* source/mulDivUnit.sv */
`timescale 1ns/10ps

module mulDivUnit (
    input logic clk,
    input logic reset,
    input logic issue,
    input execPkg::instr_t instr,
    input execPkg::word_t opA,
    input execPkg::word_t opB,
    output logic mulHit,
    output execPkg::word_t mulResult,
    output execPkg::regIdx_t mulDest,
    output logic stall
);

    logic isMult;
    logic isDiv;
    logic isSigned;
    logic readHi;
    logic readLo;
    logic writeHi;
    logic writeLo;
    logic isMulDiv;
    logic busy;
    logic divByZero;
    logic [execPkg::BusyWidth-1:0] busyCount;
    logic [63:0] product;
    execPkg::word_t quotient;
    execPkg::word_t remainder;
    execPkg::word_t hi;
    execPkg::word_t lo;
    execPkg::word_t pendHi;
    execPkg::word_t pendLo;

    always_comb begin
        isMult = 1'b0;
        isDiv = 1'b0;
        isSigned = 1'b0;
        readHi = 1'b0;
        readLo = 1'b0;
        writeHi = 1'b0;
        writeLo = 1'b0;
        if (instr.rType.opcode == execPkg::OpSpecial) begin
            case (instr.rType.funct)
                execPkg::FnMult: begin
                    isMult = 1'b1;
                    isSigned = 1'b1;
                end
                execPkg::FnMultu: isMult = 1'b1;
                execPkg::FnDiv: begin
                    isDiv = 1'b1;
                    isSigned = 1'b1;
                end
                execPkg::FnDivu: isDiv = 1'b1;
                execPkg::FnMfhi: readHi = 1'b1;
                execPkg::FnMflo: readLo = 1'b1;
                execPkg::FnMthi: writeHi = 1'b1;
                execPkg::FnMtlo: writeLo = 1'b1;
                default: ;
            endcase
        end
    end

    assign isMulDiv = isMult || isDiv || readHi || readLo || writeHi || writeLo;
    assign busy = busyCount != '0;

    // Anything touching HI/LO waits for the running operation
    assign stall = issue && busy && isMulDiv;
    assign mulHit = issue && !stall && isMulDiv;

    assign mulResult = readHi ? hi : lo;
    assign mulDest = (readHi || readLo) ? instr.rType.rd : '0;

    // Full-width operands, low 64 bits hold the product
    always_comb begin
        if (isSigned) begin
            product = {{32{opA[31]}}, opA} * {{32{opB[31]}}, opB};
        end else begin
            product = {32'h0, opA} * {32'h0, opB};
        end
    end

    assign divByZero = opB == '0;

    always_comb begin
        quotient = '0;
        remainder = '0;
        if (!divByZero) begin
            if (isSigned) begin
                quotient = execPkg::word_t'($signed(opA) / $signed(opB));
                remainder = execPkg::word_t'($signed(opA) % $signed(opB));
            end else begin
                quotient = opA / opB;
                remainder = opA % opB;
            end
        end
    end

    // Result waits here until the counter runs out
    always_ff @(posedge clk) begin
        if (mulHit && isMult) begin
            {pendHi, pendLo} <= product;
        end else if (mulHit && isDiv) begin
            pendHi <= divByZero ? hi : remainder;
            pendLo <= divByZero ? lo : quotient;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busyCount <= '0;
            hi <= '0;
            lo <= '0;
        end else begin
            if (mulHit && isMult) begin
                busyCount <= execPkg::MulLatency;
            end else if (mulHit && isDiv) begin
                busyCount <= execPkg::DivLatency;
            end else if (busy) begin
                busyCount <= busyCount - 1'b1;
            end

            if (busyCount == execPkg::BusyWidth'(1)) begin
                hi <= pendHi;
                lo <= pendLo;
            end else if (mulHit && writeHi) begin
                hi <= opA;
            end else if (mulHit && writeLo) begin
                lo <= opA;
            end
        end
    end

    // Stall only while an accepted multiply or divide is still running
    stallNeedsIssue: assert property (
        @(posedge clk) disable iff (reset)
        stall |-> issue && ($past(busy) || $past(mulHit && (isMult || isDiv))));

    busyCountBounded: assert property (
        @(posedge clk) disable iff (reset) busyCount <= execPkg::DivLatency);

endmodule

/* source/aluUnit.sv */
`timescale 1ns/10ps

module aluUnit (
    input logic issue,
    input logic stall,
    input execPkg::instr_t instr,
    input execPkg::word_t opA,
    input execPkg::word_t opB,
    output logic aluHit,
    output execPkg::word_t aluResult,
    output execPkg::regIdx_t aluDest,
    output logic aluOverflow
);

    logic [5:0] opcode;
    logic [5:0] funct;
    logic isRType;
    logic isAlu;
    logic signedOverflow;
    execPkg::word_t immSigned;
    execPkg::word_t immZero;
    execPkg::word_t operandB;
    execPkg::word_t value;

    assign opcode = instr.rType.opcode;
    assign funct = instr.rType.funct;
    assign isRType = opcode == execPkg::OpSpecial;

    assign immSigned = {{16{instr.iType.imm[15]}}, instr.iType.imm};
    assign immZero = {16'h0000, instr.iType.imm};

    // Second operand: register or immediate
    always_comb begin
        case (opcode)
            execPkg::OpAddi, execPkg::OpAddiu, execPkg::OpSlti: operandB = immSigned;
            execPkg::OpAndi, execPkg::OpOri, execPkg::OpXori: operandB = immZero;
            execPkg::OpLui: operandB = {instr.iType.imm, 16'h0000};
            default: operandB = opB;
        endcase
    end

    always_comb begin
        isAlu = 1'b1;
        signedOverflow = 1'b0;
        value = '0;
        if (isRType) begin
            case (funct)
                execPkg::FnAdd: begin
                    value = opA + operandB;
                    signedOverflow = (opA[31] == operandB[31]) && (value[31] != opA[31]);
                end
                execPkg::FnAddu: value = opA + operandB;
                execPkg::FnSub: begin
                    value = opA - operandB;
                    signedOverflow = (opA[31] != operandB[31]) && (value[31] != opA[31]);
                end
                execPkg::FnSubu: value = opA - operandB;
                execPkg::FnAnd: value = opA & operandB;
                execPkg::FnOr: value = opA | operandB;
                execPkg::FnXor: value = opA ^ operandB;
                execPkg::FnNor: value = ~(opA | operandB);
                execPkg::FnSlt: value = {31'b0, $signed(opA) < $signed(operandB)};
                execPkg::FnSltu: value = {31'b0, opA < operandB};
                // Shifts move rt by shamt
                execPkg::FnSll: value = operandB << instr.rType.shamt;
                execPkg::FnSrl: value = operandB >> instr.rType.shamt;
                execPkg::FnSra: begin
                    value = execPkg::word_t'($signed(operandB) >>> instr.rType.shamt);
                end
                default: isAlu = 1'b0;
            endcase
        end else begin
            case (opcode)
                execPkg::OpAddi: begin
                    value = opA + operandB;
                    signedOverflow = (opA[31] == operandB[31]) && (value[31] != opA[31]);
                end
                execPkg::OpAddiu: value = opA + operandB;
                execPkg::OpSlti: value = {31'b0, $signed(opA) < $signed(operandB)};
                execPkg::OpAndi: value = opA & operandB;
                execPkg::OpOri: value = opA | operandB;
                execPkg::OpXori: value = opA ^ operandB;
                execPkg::OpLui: value = operandB;
                default: isAlu = 1'b0;
            endcase
        end
    end

    assign aluHit = issue && !stall && isAlu;
    assign aluResult = value;
    assign aluDest = isRType ? instr.rType.rd : instr.iType.rt;
    assign aluOverflow = signedOverflow;

endmodule

/* source/execPkg.sv */
package execPkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0] regIdx_t;

    // One instruction word, decoded as R-type or I-type
    typedef union packed {
        struct packed {
            logic [5:0] opcode;
            regIdx_t rs;
            regIdx_t rt;
            regIdx_t rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } rType;
        struct packed {
            logic [5:0] opcode;
            regIdx_t rs;
            regIdx_t rt;
            logic [15:0] imm;
        } iType;
    } instr_t;

    // Primary opcodes
    localparam logic [5:0] OpSpecial = 6'h00;
    localparam logic [5:0] OpAddi = 6'h08;
    localparam logic [5:0] OpAddiu = 6'h09;
    localparam logic [5:0] OpSlti = 6'h0a;
    localparam logic [5:0] OpAndi = 6'h0c;
    localparam logic [5:0] OpOri = 6'h0d;
    localparam logic [5:0] OpXori = 6'h0e;
    localparam logic [5:0] OpLui = 6'h0f;

    // SPECIAL funct codes for the ALU
    localparam logic [5:0] FnSll = 6'h00;
    localparam logic [5:0] FnSrl = 6'h02;
    localparam logic [5:0] FnSra = 6'h03;
    localparam logic [5:0] FnAdd = 6'h20;
    localparam logic [5:0] FnAddu = 6'h21;
    localparam logic [5:0] FnSub = 6'h22;
    localparam logic [5:0] FnSubu = 6'h23;
    localparam logic [5:0] FnAnd = 6'h24;
    localparam logic [5:0] FnOr = 6'h25;
    localparam logic [5:0] FnXor = 6'h26;
    localparam logic [5:0] FnNor = 6'h27;
    localparam logic [5:0] FnSlt = 6'h2a;
    localparam logic [5:0] FnSltu = 6'h2b;

    // SPECIAL funct codes for multiply/divide
    localparam logic [5:0] FnMfhi = 6'h10;
    localparam logic [5:0] FnMthi = 6'h11;
    localparam logic [5:0] FnMflo = 6'h12;
    localparam logic [5:0] FnMtlo = 6'h13;
    localparam logic [5:0] FnMult = 6'h18;
    localparam logic [5:0] FnMultu = 6'h19;
    localparam logic [5:0] FnDiv = 6'h1a;
    localparam logic [5:0] FnDivu = 6'h1b;

    // Busy counter wide enough for the longest operation
    localparam int BusyWidth = 4;
    localparam logic [BusyWidth-1:0] MulLatency = BusyWidth'(5);
    localparam logic [BusyWidth-1:0] DivLatency = BusyWidth'(10);

endpackage
